/* rtl/mipsCore_defines.svh */
`ifndef MIPS_CORE_DEFINES_SVH
`define MIPS_CORE_DEFINES_SVH

// datapath and address width
`define XLEN 32

// register index width, 32 GPRs
`define REG_ADDR_W 5

// entries between fetch and execute
`define FETCH_QUEUE_DEPTH 4

`define RESET_PC 32'hBFC0_0000 // boot vector

`endif

/* rtl/mipsPkg.sv */
`default_nettype none

`include "mipsCore_defines.svh"

package mipsPkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] regAddr_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        NOR,
        SLT,
        SLTU,
        LUI,
        NONE // retires without a write
    } aluOp_t;

    typedef enum logic [0:0] {
        FETCH_REQ,
        FETCH_HOLD
    } fetchState_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetchEntry_t;

    // wishbone classic, master side
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        word_t      adr;
        logic [3:0] sel;
        word_t      datW;
    } wbReq_t;

    typedef struct packed {
        logic  ack;
        word_t datR;
    } wbRsp_t;

    typedef struct packed {
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t wreg;
        word_t    imm;
        logic     useImm;
        logic     regWrite;
        aluOp_t   aluOp;
    } decoded_t;

    typedef struct packed {
        word_t      pc;
        logic [3:0] rfWen;
        regAddr_t   rfWnum;
        word_t      rfWdata;
    } debugWb_t;

endpackage

`default_nettype wire

/* rtl/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_defines.svh"

module fetchUnit import mipsPkg::*; (
    input  logic        clk,
    input  logic        rst,
    output wbReq_t      wbReq,
    input  wbRsp_t      wbRsp,
    input  logic        full,
    output logic        pushValid,
    output fetchEntry_t pushEntry
);

    fetchState_t state;
    fetchState_t stateNext;
    word_t       pc;
    logic        reqActive;
    logic        accept;

    // full cannot rise while a request is out, so stb holds until ack
    assign reqActive = (state == FETCH_REQ) && !full;
    assign accept = reqActive && wbRsp.ack;

    always_comb begin
        wbReq.cyc = reqActive;
        wbReq.stb = reqActive;
        wbReq.we = 1'b0; // instruction side never writes
        wbReq.adr = pc;
        wbReq.sel = 4'hF;
        wbReq.datW = '0;
    end

    always_comb begin
        stateNext = state;
        case (state)
            FETCH_REQ: begin
                if (full) begin
                    stateNext = FETCH_HOLD;
                end
            end
            FETCH_HOLD: begin
                if (!full) begin
                    stateNext = FETCH_REQ;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH_HOLD;
            pc <= `RESET_PC;
        end else begin
            state <= stateNext;
            if (accept) begin
                pc <= pc + word_t'(4); // sequential fetch only
            end
        end
    end

    assign pushValid = accept;
    assign pushEntry = '{pc: pc, instr: wbRsp.datR};

    // classic handshake: request is frozen until acknowledged
    adrHeld: assert property (@(posedge clk) disable iff (rst)
        wbReq.stb && !wbRsp.ack |=> wbReq.stb && $stable(wbReq.adr));

endmodule

`default_nettype wire

/* rtl/fetchQueue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_defines.svh"

module fetchQueue import mipsPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        pushValid,
    input  fetchEntry_t pushEntry,
    input  logic        pop,
    output logic        full,
    output logic        empty,
    output fetchEntry_t headEntry
);

    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetchEntry_t      mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign headEntry = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({pushValid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count; // idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pushValid) begin
            mem[wrPtr] <= pushEntry;
        end
    end

    // fetch side must hold stb off while full
    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        pushValid |-> !full);

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty);

endmodule

`default_nettype wire

/* rtl/instDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instDecoder import mipsPkg::*; (
    input  word_t    instr,
    output decoded_t dec
);

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI = 6'h0A;
    localparam logic [5:0] OP_ANDI = 6'h0C;
    localparam logic [5:0] OP_ORI = 6'h0D;
    localparam logic [5:0] OP_XORI = 6'h0E;
    localparam logic [5:0] OP_LUI = 6'h0F;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_NOR = 6'h27;
    localparam logic [5:0] FN_SLT = 6'h2A;
    localparam logic [5:0] FN_SLTU = 6'h2B;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       zeroExt;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];

    always_comb begin
        dec.rs = instr[25:21];
        dec.rt = instr[20:16];
        dec.wreg = (opcode == OP_SPECIAL) ? instr[15:11] : instr[20:16]; // rd or rt
        dec.useImm = (opcode != OP_SPECIAL);
        dec.aluOp = NONE;
        zeroExt = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADDU: dec.aluOp = ADD;
                    FN_SUBU: dec.aluOp = SUB;
                    FN_AND: dec.aluOp = AND;
                    FN_OR: dec.aluOp = OR;
                    FN_XOR: dec.aluOp = XOR;
                    FN_NOR: dec.aluOp = NOR;
                    FN_SLT: dec.aluOp = SLT;
                    FN_SLTU: dec.aluOp = SLTU;
                    default: dec.aluOp = NONE; // includes sll $0 nop
                endcase
            end
            OP_ADDIU: dec.aluOp = ADD;
            OP_SLTI: dec.aluOp = SLT;
            OP_LUI: dec.aluOp = LUI;
            OP_ANDI: begin
                dec.aluOp = AND;
                zeroExt = 1'b1;
            end
            OP_ORI: begin
                dec.aluOp = OR;
                zeroExt = 1'b1;
            end
            OP_XORI: begin
                dec.aluOp = XOR;
                zeroExt = 1'b1;
            end
            default: dec.aluOp = NONE;
        endcase
        // logical immediates zero extend
        dec.imm = zeroExt ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
        dec.regWrite = (dec.aluOp != NONE);
    end

endmodule

`default_nettype wire

/* rtl/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_defines.svh"

module regFile import mipsPkg::*; (
    input  logic     clk,
    input  regAddr_t raddrA,
    input  regAddr_t raddrB,
    output word_t    rdataA,
    output word_t    rdataB,
    input  logic     we,
    input  regAddr_t waddr,
    input  word_t    wdata
);

    word_t regs [2**`REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata; // $zero stays zero
        end
    end

    // asynchronous read, $zero hardwired
    assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

`default_nettype wire

/* rtl/execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit import mipsPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        empty,
    input  fetchEntry_t headEntry,
    output logic        pop,
    output debugWb_t    debugWb
);

    decoded_t dec;
    word_t    rdataA;
    word_t    rdataB;
    word_t    opB;
    word_t    aluResult;
    logic     wen;

    // one entry per cycle, never stalls
    assign pop = !empty;

    instDecoder instDecoder0 (
        .instr(headEntry.instr),
        .dec  (dec)
    );

    regFile regFile0 (
        .clk   (clk),
        .raddrA(dec.rs),
        .raddrB(dec.rt),
        .rdataA(rdataA),
        .rdataB(rdataB),
        .we    (wen),
        .waddr (dec.wreg),
        .wdata (aluResult)
    );

    assign opB = dec.useImm ? dec.imm : rdataB;

    always_comb begin
        case (dec.aluOp)
            ADD: aluResult = rdataA + opB; // wraps, no overflow trap
            SUB: aluResult = rdataA - opB;
            AND: aluResult = rdataA & opB;
            OR: aluResult = rdataA | opB;
            XOR: aluResult = rdataA ^ opB;
            NOR: aluResult = ~(rdataA | opB);
            SLT: aluResult = word_t'($signed(rdataA) < $signed(opB));
            SLTU: aluResult = word_t'(rdataA < opB);
            LUI: aluResult = {opB[15:0], 16'h0000};
            default: aluResult = '0;
        endcase
    end

    assign wen = pop && dec.regWrite && (dec.wreg != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            debugWb.rfWen <= '0;
        end else begin
            debugWb.rfWen <= {4{wen}};
        end
        if (pop) begin
            debugWb.pc <= headEntry.pc;
            debugWb.rfWnum <= dec.wreg;
            debugWb.rfWdata <= aluResult;
        end
    end

    // writes to $zero retire silently
    noWbToZero: assert property (@(posedge clk) disable iff (rst)
        (debugWb.rfWen != '0) |-> (debugWb.rfWnum != '0));

endmodule

`default_nettype wire

/* rtl/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore import mipsPkg::*; (
    input  logic     clk,
    input  logic     rst,
    output wbReq_t   wbReq,
    input  wbRsp_t   wbRsp,
    output debugWb_t debugWb
);

    logic        pushValid;
    fetchEntry_t pushEntry;
    logic        full;
    logic        empty;
    logic        pop;
    fetchEntry_t headEntry;

    fetchUnit fetchUnit0 (
        .clk      (clk),
        .rst      (rst),
        .wbReq    (wbReq),
        .wbRsp    (wbRsp),
        .full     (full),
        .pushValid(pushValid),
        .pushEntry(pushEntry)
    );

    // decouples bus latency from execute
    fetchQueue fetchQueue0 (
        .clk      (clk),
        .rst      (rst),
        .pushValid(pushValid),
        .pushEntry(pushEntry),
        .pop      (pop),
        .full     (full),
        .empty    (empty),
        .headEntry(headEntry)
    );

    execUnit execUnit0 (
        .clk      (clk),
        .rst      (rst),
        .empty    (empty),
        .headEntry(headEntry),
        .pop      (pop),
        .debugWb  (debugWb)
    );

endmodule

`default_nettype wire

/* dv/mipsCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_defines.svh"

module mipsCoreTb import mipsPkg::*; ();

    localparam int PROG_LEN = 200;
    localparam int RUN_TIMEOUT = 6000; // cycles
    localparam int IDLE_LIMIT = 40;
    localparam int DELAY_SLOTS = 256;

    typedef enum int {
        INS_ADDU, INS_SUBU, INS_AND, INS_OR, INS_XOR, INS_NOR, INS_SLT, INS_SLTU,
        INS_ADDIU, INS_SLTI, INS_ANDI, INS_ORI, INS_XORI, INS_LUI, INS_BAD
    } insKind_t;

    logic     clk;
    logic     rst;
    wbReq_t   wbReq;
    wbRsp_t   wbRsp;
    debugWb_t debugWb;

    insKind_t    kinds [PROG_LEN];
    regAddr_t    srcA [PROG_LEN];
    regAddr_t    srcB [PROG_LEN];
    regAddr_t    dest [PROG_LEN];
    logic [15:0] imms [PROG_LEN];
    word_t       progWords [PROG_LEN];
    int          ackDelays [DELAY_SLOTS];
    word_t       modelRegs [32];
    int          nextIdx = 0; // next program index that may write back
    int          writerCount = 0;
    int          checkedCount = 0;
    int          ackCount = 0;

    mipsCore dut (
        .clk    (clk),
        .rst    (rst),
        .wbReq  (wbReq),
        .wbRsp  (wbRsp),
        .debugWb(debugWb)
    );

    task automatic reportMismatch(input string name, input word_t got, input word_t exp);
        $display("SOME TESTS FAILED");
        $display("FAILED %s: got %h expected %h", name, got, exp);
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic reportProblem(input string what);
        $display("SOME TESTS FAILED");
        $display("%s", what);
        $fatal(1, "%s", what);
    endtask

    function automatic word_t encodeInstr(input insKind_t k, input regAddr_t rs,
                                          input regAddr_t rt, input regAddr_t rd,
                                          input logic [15:0] imm);
        case (k)
            INS_ADDU: return {6'h00, rs, rt, rd, 5'h00, 6'h21};
            INS_SUBU: return {6'h00, rs, rt, rd, 5'h00, 6'h23};
            INS_AND: return {6'h00, rs, rt, rd, 5'h00, 6'h24};
            INS_OR: return {6'h00, rs, rt, rd, 5'h00, 6'h25};
            INS_XOR: return {6'h00, rs, rt, rd, 5'h00, 6'h26};
            INS_NOR: return {6'h00, rs, rt, rd, 5'h00, 6'h27};
            INS_SLT: return {6'h00, rs, rt, rd, 5'h00, 6'h2A};
            INS_SLTU: return {6'h00, rs, rt, rd, 5'h00, 6'h2B};
            INS_ADDIU: return {6'h09, rs, rt, imm};
            INS_SLTI: return {6'h0A, rs, rt, imm};
            INS_ANDI: return {6'h0C, rs, rt, imm};
            INS_ORI: return {6'h0D, rs, rt, imm};
            INS_XORI: return {6'h0E, rs, rt, imm};
            INS_LUI: return {6'h0F, 5'h00, rt, imm};
            default: return imm[0] ? {6'h23, rs, rt, imm} : {6'h00, rs, rt, rd, 5'h00, 6'h20};
        endcase
    endfunction

    function automatic logic writesReg(input int i);
        return (kinds[i] != INS_BAD) && (dest[i] != '0);
    endfunction

    function automatic word_t expectedResult(input int i);
        word_t a;
        word_t b;
        word_t sx;
        word_t zx;
        a = modelRegs[srcA[i]];
        b = modelRegs[srcB[i]];
        sx = {{16{imms[i][15]}}, imms[i]};
        zx = {16'h0000, imms[i]};
        case (kinds[i])
            INS_ADDU: return a + b;
            INS_SUBU: return a - b;
            INS_AND: return a & b;
            INS_OR: return a | b;
            INS_XOR: return a ^ b;
            INS_NOR: return ~(a | b);
            INS_SLT: return {31'b0, $signed(a) < $signed(b)};
            INS_SLTU: return {31'b0, a < b};
            INS_ADDIU: return a + sx;
            INS_SLTI: return {31'b0, $signed(a) < $signed(sx)};
            INS_ANDI: return a & zx;
            INS_ORI: return a | zx;
            INS_XORI: return a ^ zx;
            INS_LUI: return {imms[i], 16'h0000};
            default: return '0;
        endcase
    endfunction

    // zero words past the end of the program
    function automatic word_t memWord(input word_t adr);
        word_t offset;
        offset = adr - `RESET_PC;
        if (offset[1:0] == 2'b00 && offset < word_t'(4 * PROG_LEN)) begin
            return progWords[int'(offset >> 2)];
        end
        return '0;
    endfunction

    task automatic buildProgram();
        insKind_t    k;
        regAddr_t    rs;
        regAddr_t    rt;
        regAddr_t    rd;
        logic [15:0] imm;
        for (int i = 0; i < PROG_LEN; i++) begin
            k = ($urandom_range(0, 99) < 6) ? INS_BAD : insKind_t'($urandom_range(0, 13));
            rs = regAddr_t'($urandom_range(0, 31));
            rt = regAddr_t'($urandom_range(0, 31));
            rd = regAddr_t'($urandom_range(0, 31));
            imm = 16'($urandom_range(0, 16'hFFFF));
            if (i < 31) begin
                k = INS_LUI; // gives every GPR a known value first
                rt = regAddr_t'(i + 1);
            end
            kinds[i] = k;
            srcA[i] = rs;
            srcB[i] = rt;
            imms[i] = imm;
            dest[i] = (k <= INS_SLTU) ? rd : rt;
            progWords[i] = encodeInstr(k, rs, rt, rd, imm);
            if (writesReg(i)) begin
                writerCount++;
            end
        end
        for (int i = 0; i < DELAY_SLOTS; i++) begin
            // alternate stretches: random waits, then ack every cycle
            ackDelays[i] = ((i / 24) % 2 == 1) ? 0 : int'($urandom_range(0, 5));
        end
    endtask

    task automatic checkWriteBack();
        word_t expData;
        word_t expPc;
        assert (debugWb.rfWen == 4'hF)
            else reportMismatch("debugWb.rfWen", word_t'(debugWb.rfWen), 32'h0000_000F);
        while (nextIdx < PROG_LEN && !writesReg(nextIdx)) begin
            nextIdx++; // no-ops, bad words and $zero targets retire silently
        end
        assert (nextIdx < PROG_LEN)
            else reportProblem("write-back seen after the last writing instruction");
        expPc = `RESET_PC + word_t'(4 * nextIdx);
        expData = expectedResult(nextIdx);
        assert (debugWb.pc == expPc) else reportMismatch("debugWb.pc", debugWb.pc, expPc);
        assert (debugWb.rfWnum == dest[nextIdx])
            else reportMismatch("debugWb.rfWnum", word_t'(debugWb.rfWnum), word_t'(dest[nextIdx]));
        assert (debugWb.rfWdata == expData)
            else reportMismatch("debugWb.rfWdata", debugWb.rfWdata, expData);
        modelRegs[dest[nextIdx]] = expData;
        nextIdx++;
        checkedCount++;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // wishbone slave, answers on the falling edge
    initial begin
        int    delay;
        int    idle;
        word_t heldAdr;
        word_t expAdr;
        wbRsp = '0;
        idle = 0;
        forever begin
            @(negedge clk);
            wbRsp.ack = 1'b0;
            wbRsp.datR = '0;
            if (rst) begin
                idle = 0;
            end else if (!wbReq.stb) begin
                idle++;
                assert (idle < IDLE_LIMIT) else reportProblem("fetch unit stopped requesting");
            end else begin
                idle = 0;
                heldAdr = wbReq.adr;
                expAdr = `RESET_PC + word_t'(4 * ackCount);
                assert (wbReq.cyc && !wbReq.we)
                    else reportProblem("request without cyc or with we set");
                assert (wbReq.sel == 4'hF)
                    else reportMismatch("wbReq.sel", word_t'(wbReq.sel), 32'h0000_000F);
                assert (wbReq.datW == 32'h0000_0000)
                    else reportMismatch("wbReq.datW", wbReq.datW, 32'h0000_0000);
                assert (heldAdr == expAdr) else reportMismatch("wbReq.adr", heldAdr, expAdr);
                delay = ackDelays[ackCount % DELAY_SLOTS];
                while (delay > 0) begin
                    @(negedge clk);
                    delay--;
                    assert (wbReq.stb) else reportProblem("stb dropped before ack");
                    assert (wbReq.adr == heldAdr)
                        else reportMismatch("wbReq.adr", wbReq.adr, heldAdr);
                end
                wbRsp.ack = 1'b1;
                wbRsp.datR = memWord(heldAdr);
                ackCount++;
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (!rst && debugWb.rfWen != 4'h0) begin
                checkWriteBack();
            end
        end
    end

    initial begin
        int cycles;
        void'($urandom(32'h1805_96cf));
        rst = 1'b1;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        buildProgram();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        cycles = 0;
        while (checkedCount < writerCount) begin
            @(negedge clk);
            cycles++;
            assert (cycles <= RUN_TIMEOUT)
                else reportProblem("timeout waiting for the program to retire");
        end
        repeat (20) @(negedge clk); // trailing zero words must stay silent
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* mipsCore.f */
+incdir+rtl
rtl/mipsPkg.sv
rtl/fetchUnit.sv
rtl/fetchQueue.sv
rtl/instDecoder.sv
rtl/regFile.sv
rtl/execUnit.sv
rtl/mipsCore.sv
dv/mipsCoreTb.sv

/* Makefile */
BUILD_DIR := build

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module mipsCoreTb \
		--Mdir $(BUILD_DIR) -f mipsCore.f
	@out="$$(./$(BUILD_DIR)/VmipsCoreTb)"; echo "$$out"; \
		echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
